// File: verilog/exu_consts.svh
`ifndef EXU_CONSTS_SVH
`define EXU_CONSTS_SVH

// alu operation codes
`define EXU_ALU_ADD  4'd0
`define EXU_ALU_SUB  4'd1
`define EXU_ALU_XOR  4'd2
`define EXU_ALU_OR   4'd3
`define EXU_ALU_AND  4'd4
`define EXU_ALU_SLL  4'd5
`define EXU_ALU_SRL  4'd6
`define EXU_ALU_SRA  4'd7
`define EXU_ALU_SLT  4'd8
`define EXU_ALU_SLTU 4'd9
`define EXU_ALU_SLE  4'd10
`define EXU_ALU_SLEU 4'd11

// major opcodes
`define EXU_OP_B      7'b1100011
`define EXU_OP_JAL    7'b1101111
`define EXU_OP_JALR   7'b1100111
`define EXU_OP_LOAD   7'b0000011
`define EXU_OP_STORE  7'b0100011
`define EXU_OP_SYSTEM 7'b1110011

// system function, carried in imm[15:4]
`define EXU_SYS_ECALL 12'h000
`define EXU_SYS_MRET  12'h302

// csr variant, carried in imm[3:0]
`define EXU_CSRRW  4'd1
`define EXU_CSRRS  4'd2
`define EXU_CSRRC  4'd3
`define EXU_CSRRWI 4'd5
`define EXU_CSRRSI 4'd6
`define EXU_CSRRCI 4'd7

// machine csr addresses
`define EXU_CSR_MSTATUS 12'h300
`define EXU_CSR_MTVEC   12'h305
`define EXU_CSR_MEPC    12'h341
`define EXU_CSR_MCAUSE  12'h342

`define EXU_CAUSE_ECALL 32'd11

// data memory
`define EXU_MEM_WORDS    64
`define EXU_MEM_BASE_LAT 1

`endif

// File: verilog/exu_pkg.sv
`default_nettype none

package exu_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [3:0]  reg_idx_t;
  typedef logic [11:0] csr_addr_t;
  typedef logic [3:0]  alu_op_t;
  typedef logic [6:0]  opcode_t;

  // decoded instruction from issue
  typedef struct packed {
    xlen_t    pc;
    xlen_t    op1;
    xlen_t    op2;
    xlen_t    op_j;
    // [15:4] csr address or system function, [3:0] csr variant
    xlen_t    imm;
    alu_op_t  alu_op;
    opcode_t  opcode;
    reg_idx_t rd;
    logic     ren;
    logic     wen;
    logic     system;
    logic     system_func3;
    logic     csr_wen;
  } exu_req_t;

  // result towards writeback
  typedef struct packed {
    reg_idx_t rd;
    xlen_t    reg_wdata;
    xlen_t    npc;
    logic     use_npc;
    logic     retire_branch;
    xlen_t    pc;
  } exu_res_t;

  // word request to the load/store unit
  typedef struct packed {
    xlen_t addr;
    xlen_t wdata;
    logic  we;
  } mem_req_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_EXEC,
    ST_MEM,
    ST_HOLD
  } exu_state_e;

endpackage

`default_nettype wire

// File: verilog/exu_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_alu (
  input  exu_pkg::xlen_t   a_i,
  input  exu_pkg::xlen_t   b_i,
  input  exu_pkg::alu_op_t op_i,
  output exu_pkg::xlen_t   res_o
);
  import exu_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      `EXU_ALU_ADD: begin
        res_o = a_i + b_i;
      end
      // branches test this one for zero
      `EXU_ALU_SUB: begin
        res_o = a_i - b_i;
      end
      `EXU_ALU_XOR: begin
        res_o = a_i ^ b_i;
      end
      `EXU_ALU_OR: begin
        res_o = a_i | b_i;
      end
      `EXU_ALU_AND: begin
        res_o = a_i & b_i;
      end
      `EXU_ALU_SLL: begin
        res_o = a_i << shamt;
      end
      `EXU_ALU_SRL: begin
        res_o = a_i >> shamt;
      end
      `EXU_ALU_SRA: begin
        res_o = xlen_t'($signed(a_i) >>> shamt);
      end
      // compares give 1 or 0
      `EXU_ALU_SLT: begin
        res_o = xlen_t'($signed(a_i) < $signed(b_i));
      end
      `EXU_ALU_SLTU: begin
        res_o = xlen_t'(a_i < b_i);
      end
      `EXU_ALU_SLE: begin
        res_o = xlen_t'($signed(a_i) <= $signed(b_i));
      end
      `EXU_ALU_SLEU: begin
        res_o = xlen_t'(a_i <= b_i);
      end
      default: begin
        res_o = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: verilog/exu_csr.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_csr (
  input  logic               clk,
  input  logic               rst,
  input  logic               we_i,
  input  logic               ecall_i,
  input  exu_pkg::csr_addr_t waddr_i,
  input  exu_pkg::xlen_t     wdata_i,
  input  exu_pkg::xlen_t     epc_i,
  output exu_pkg::xlen_t     rdata_o,
  output exu_pkg::xlen_t     mtvec_o,
  output exu_pkg::xlen_t     mepc_o
);
  import exu_pkg::*;

  xlen_t mstatus_q;
  xlen_t mtvec_q;
  xlen_t mepc_q;
  xlen_t mcause_q;

  // read shares the write address
  always_comb begin
    case (waddr_i)
      `EXU_CSR_MSTATUS: begin
        rdata_o = mstatus_q;
      end
      `EXU_CSR_MTVEC: begin
        rdata_o = mtvec_q;
      end
      `EXU_CSR_MEPC: begin
        rdata_o = mepc_q;
      end
      `EXU_CSR_MCAUSE: begin
        rdata_o = mcause_q;
      end
      default: begin
        rdata_o = '0;
      end
    endcase
  end

  assign mtvec_o = mtvec_q;
  assign mepc_o  = mepc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      if (we_i) begin
        case (waddr_i)
          `EXU_CSR_MSTATUS: mstatus_q <= wdata_i;
          `EXU_CSR_MTVEC:   mtvec_q   <= wdata_i;
          `EXU_CSR_MEPC:    mepc_q    <= wdata_i;
          `EXU_CSR_MCAUSE:  mcause_q  <= wdata_i;
          default: ;
        endcase
      end
      // trap side write
      if (ecall_i) begin
        mepc_q   <= epc_i;
        mcause_q <= `EXU_CAUSE_ECALL;
      end
    end
  end

  // stage must never aim the main port at mepc during an ecall
  assert property (@(posedge clk) disable iff (rst)
    !(we_i && ecall_i && (waddr_i == `EXU_CSR_MEPC)))
    else $error("csr: main write and ecall both target mepc");

endmodule

`default_nettype wire

// File: verilog/exu_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_stage (
  input  logic               clk,
  input  logic               rst,
  input  exu_pkg::exu_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output exu_pkg::exu_res_t  res_o,
  output logic               res_valid_o,
  input  logic               res_ready_i,
  output exu_pkg::mem_req_t  mem_req_o,
  output logic               mem_avalid_o,
  input  logic               mem_wready_i,
  input  logic               mem_rvalid_i,
  input  exu_pkg::xlen_t     mem_rdata_i,
  output exu_pkg::xlen_t     alu_a_o,
  output exu_pkg::xlen_t     alu_b_o,
  output exu_pkg::alu_op_t   alu_op_o,
  input  exu_pkg::xlen_t     alu_res_i,
  output logic               csr_we_o,
  output logic               csr_ecall_o,
  output exu_pkg::csr_addr_t csr_addr_o,
  output exu_pkg::xlen_t     csr_wdata_o,
  output exu_pkg::xlen_t     csr_epc_o,
  input  exu_pkg::xlen_t     csr_rdata_i,
  input  exu_pkg::xlen_t     csr_mtvec_i,
  input  exu_pkg::xlen_t     csr_mepc_i
);
  import exu_pkg::*;

  exu_state_e state_q;
  exu_req_t   issue_q;
  xlen_t      target_q;
  exu_res_t   res_q;
  exu_res_t   res_d;
  logic       avalid_q;
  logic       accept;
  logic       retire;
  logic       mem_done;
  logic       is_sysfn;
  logic       is_ecall;
  logic       is_mret;
  logic       take;

  assign accept   = req_valid_i & req_ready_o;
  assign retire   = res_valid_o & res_ready_i;
  assign mem_done = avalid_q & (mem_wready_i | mem_rvalid_i);

  assign req_ready_o = (state_q == ST_IDLE) | retire;
  assign res_valid_o = (state_q == ST_HOLD);
  assign res_o       = res_q;

  assign is_sysfn = issue_q.system & issue_q.system_func3;
  assign is_ecall = is_sysfn & (issue_q.imm[15:4] == `EXU_SYS_ECALL);
  assign is_mret  = is_sysfn & (issue_q.imm[15:4] == `EXU_SYS_MRET);

  assign alu_a_o  = issue_q.op1;
  assign alu_b_o  = issue_q.op2;
  assign alu_op_o = issue_q.alu_op;

  assign mem_req_o.addr  = target_q;
  assign mem_req_o.wdata = issue_q.op2;
  assign mem_req_o.we    = issue_q.wen;
  assign mem_avalid_o    = avalid_q;

  // redirect decision
  always_comb begin
    case (issue_q.opcode)
      `EXU_OP_JAL, `EXU_OP_JALR: begin
        take = 1'b1;
      end
      `EXU_OP_SYSTEM: begin
        take = is_ecall | is_mret;
      end
      `EXU_OP_B: begin
        case (issue_q.alu_op)
          `EXU_ALU_SUB: take = ~|alu_res_i;
          `EXU_ALU_XOR, `EXU_ALU_SLT, `EXU_ALU_SLTU,
          `EXU_ALU_SLE, `EXU_ALU_SLEU: take = |alu_res_i;
          default: take = 1'b0;
        endcase
      end
      default: begin
        take = 1'b0;
      end
    endcase
  end

  // csr link, write lands when the result is taken
  assign csr_addr_o = is_ecall ? `EXU_CSR_MCAUSE :
                      is_mret  ? `EXU_CSR_MSTATUS : issue_q.imm[15:4];
  assign csr_we_o    = retire & issue_q.system & (issue_q.csr_wen | is_ecall | is_mret);
  assign csr_ecall_o = retire & is_ecall;
  assign csr_epc_o   = issue_q.pc;

  always_comb begin
    if (is_ecall) begin
      csr_wdata_o = `EXU_CAUSE_ECALL;
    end else if (is_mret) begin
      // MIE takes MPIE
      csr_wdata_o    = csr_rdata_i;
      csr_wdata_o[3] = csr_rdata_i[7];
    end else begin
      case (issue_q.imm[3:0])
        `EXU_CSRRW, `EXU_CSRRWI: csr_wdata_o = issue_q.op1;
        `EXU_CSRRS, `EXU_CSRRSI: csr_wdata_o = csr_rdata_i | issue_q.op1;
        `EXU_CSRRC, `EXU_CSRRCI: csr_wdata_o = csr_rdata_i & ~issue_q.op1;
        default: csr_wdata_o = csr_rdata_i;
      endcase
    end
  end

  always_comb begin
    res_d.rd            = issue_q.rd;
    res_d.pc            = issue_q.pc;
    res_d.use_npc       = take;
    res_d.retire_branch = issue_q.system | (issue_q.opcode == `EXU_OP_B) |
                          (issue_q.opcode == `EXU_OP_LOAD) |
                          (issue_q.opcode == `EXU_OP_STORE);
    if (is_ecall) begin
      res_d.npc = csr_mtvec_i;
    end else if (is_mret) begin
      res_d.npc = csr_mepc_i;
    end else begin
      res_d.npc = target_q;
    end
    if (issue_q.rd == '0) begin
      res_d.reg_wdata = '0;
    end else if (issue_q.opcode == `EXU_OP_LOAD) begin
      res_d.reg_wdata = mem_rdata_i;
    end else if (issue_q.system) begin
      res_d.reg_wdata = csr_rdata_i;
    end else begin
      res_d.reg_wdata = alu_res_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q  <= ST_IDLE;
      avalid_q <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE, ST_HOLD: begin
          if (accept) begin
            state_q <= (req_i.ren | req_i.wen) ? ST_MEM : ST_EXEC;
          end else if (retire) begin
            state_q <= ST_IDLE;
          end
        end
        ST_EXEC: begin
          state_q <= ST_HOLD;
        end
        ST_MEM: begin
          // request goes out one cycle into ST_MEM
          if (mem_done) begin
            state_q  <= ST_HOLD;
            avalid_q <= 1'b0;
          end else begin
            avalid_q <= 1'b1;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      issue_q  <= req_i;
      target_q <= req_i.op_j + req_i.imm;
    end
    if ((state_q == ST_EXEC) || mem_done) begin
      res_q <= res_d;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    mem_avalid_o |-> (state_q == ST_MEM))
    else $error("stage: mem_avalid_o outside ST_MEM");

  // held result must not move under back-pressure
  assert property (@(posedge clk) disable iff (rst)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o))
    else $error("stage: res_o changed while held");

endmodule

`default_nettype wire

// File: verilog/exu_lsu.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_lsu (
  input  logic              clk,
  input  logic              rst,
  input  exu_pkg::mem_req_t req_i,
  input  logic              avalid_i,
  output logic              wready_o,
  output logic              rvalid_o,
  output exu_pkg::xlen_t    rdata_o
);
  import exu_pkg::*;

  localparam int unsigned IDX_W = $clog2(`EXU_MEM_WORDS);

  xlen_t            mem_q [`EXU_MEM_WORDS] = '{default: '0};
  logic [IDX_W-1:0] idx;
  logic [2:0]       lat;
  logic [2:0]       remain;
  logic [2:0]       cnt_q;
  logic             active_q;
  logic             start;
  logic             fire;

  // word address, upper bits dropped
  assign idx = req_i.addr[IDX_W-1:0];
  assign lat = 3'(`EXU_MEM_BASE_LAT) + 3'(req_i.addr[1:0]);

  // avalid is still up during the answer pulse
  assign start  = avalid_i & ~active_q & ~wready_o & ~rvalid_o;
  assign remain = active_q ? cnt_q : lat;
  assign fire   = (start | active_q) & (remain == 3'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
      wready_o <= 1'b0;
      rvalid_o <= 1'b0;
    end else begin
      wready_o <= fire & req_i.we;
      rvalid_o <= fire & ~req_i.we;
      active_q <= (start | active_q) & ~fire;
      if ((start | active_q) & ~fire) begin
        cnt_q <= remain - 3'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (fire & req_i.we) begin
      mem_q[idx] <= req_i.wdata;
    end
    if (fire & ~req_i.we) begin
      rdata_o <= mem_q[idx];
    end
  end

endmodule

`default_nettype wire

// File: verilog/exu_top.sv
`timescale 1ns/1ps
`default_nettype none

module exu_top (
  input  logic              clk,
  input  logic              rst,
  input  exu_pkg::exu_req_t req_i,
  input  logic              req_valid_i,
  output logic              req_ready_o,
  output exu_pkg::exu_res_t res_o,
  output logic              res_valid_o,
  input  logic              res_ready_i
);
  import exu_pkg::*;

  mem_req_t  mem_req;
  logic      mem_avalid;
  logic      mem_wready;
  logic      mem_rvalid;
  xlen_t     mem_rdata;
  xlen_t     alu_a;
  xlen_t     alu_b;
  xlen_t     alu_res;
  alu_op_t   alu_op;
  logic      csr_we;
  logic      csr_ecall;
  csr_addr_t csr_addr;
  xlen_t     csr_wdata;
  xlen_t     csr_epc;
  xlen_t     csr_rdata;
  xlen_t     csr_mtvec;
  xlen_t     csr_mepc;

  exu_stage exu_stage_i (
    .clk          (clk),
    .rst          (rst),
    .req_i        (req_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .res_o        (res_o),
    .res_valid_o  (res_valid_o),
    .res_ready_i  (res_ready_i),
    .mem_req_o    (mem_req),
    .mem_avalid_o (mem_avalid),
    .mem_wready_i (mem_wready),
    .mem_rvalid_i (mem_rvalid),
    .mem_rdata_i  (mem_rdata),
    .alu_a_o      (alu_a),
    .alu_b_o      (alu_b),
    .alu_op_o     (alu_op),
    .alu_res_i    (alu_res),
    .csr_we_o     (csr_we),
    .csr_ecall_o  (csr_ecall),
    .csr_addr_o   (csr_addr),
    .csr_wdata_o  (csr_wdata),
    .csr_epc_o    (csr_epc),
    .csr_rdata_i  (csr_rdata),
    .csr_mtvec_i  (csr_mtvec),
    .csr_mepc_i   (csr_mepc)
  );

  exu_alu exu_alu_i (
    .a_i   (alu_a),
    .b_i   (alu_b),
    .op_i  (alu_op),
    .res_o (alu_res)
  );

  exu_csr exu_csr_i (
    .clk     (clk),
    .rst     (rst),
    .we_i    (csr_we),
    .ecall_i (csr_ecall),
    .waddr_i (csr_addr),
    .wdata_i (csr_wdata),
    .epc_i   (csr_epc),
    .rdata_o (csr_rdata),
    .mtvec_o (csr_mtvec),
    .mepc_o  (csr_mepc)
  );

  exu_lsu exu_lsu_i (
    .clk      (clk),
    .rst      (rst),
    .req_i    (mem_req),
    .avalid_i (mem_avalid),
    .wready_o (mem_wready),
    .rvalid_o (mem_rvalid),
    .rdata_o  (mem_rdata)
  );

endmodule

`default_nettype wire

// File: verif/exu_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "exu_consts.svh"

module exu_tb;
  import exu_pkg::*;

  localparam int n_alu = 60;
  localparam int n_br = 24;
  localparam int n_jmp = 8;
  localparam int n_csr = 24;
  localparam int n_sys = 8;
  localparam int n_mem = 16;
  localparam int n_total = n_alu + n_br + n_jmp + n_csr + n_sys + 2 * n_mem;
  localparam int timeout_cycles = 40 * n_total + 16;
  localparam int idx_w = $clog2(`EXU_MEM_WORDS);
  localparam logic [6:0] op_reg = 7'b0110011;

  logic     clk;
  logic     rst;
  exu_req_t req_i;
  logic     req_valid_i;
  logic     req_ready_o;
  exu_res_t res_o;
  logic     res_valid_o;
  logic     res_ready_i;

  logic [15:0] stim_lfsr = 16'd25199;
  logic [15:0] stall_lfsr = 16'd25199;
  xlen_t       pc_next = 32'h0000_1000;
  xlen_t       sh_mstatus = '0;
  xlen_t       sh_mtvec = '0;
  xlen_t       sh_mepc = '0;
  xlen_t       sh_mcause = '0;
  xlen_t       sh_mem [`EXU_MEM_WORDS] = '{default: '0};
  xlen_t       addrs [n_mem];
  exu_res_t    exp_q [$];
  int          errors = 0;
  int          n_issued = 0;
  int          n_checked = 0;
  int          cycles = 0;

  exu_top exu_top_i (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .req_valid_i (req_valid_i),
    .req_ready_o (req_ready_o),
    .res_o       (res_o),
    .res_valid_o (res_valid_o),
    .res_ready_i (res_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // taps 16,14,13,11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic xlen_t rand_bits(input int n);
    xlen_t v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      stim_lfsr = lfsr_next(stim_lfsr);
      v = {v[30:0], stim_lfsr[0]};
    end
    return v;
  endfunction

  function automatic xlen_t alu_model(input xlen_t a, input xlen_t b, input alu_op_t op);
    logic lt;
    logic ltu;
    ltu = a < b;
    lt = (a[31] != b[31]) ? a[31] : ltu;
    case (op)
      `EXU_ALU_ADD: return a + b;
      `EXU_ALU_SUB: return a - b;
      `EXU_ALU_XOR: return a ^ b;
      `EXU_ALU_OR: return a | b;
      `EXU_ALU_AND: return a & b;
      `EXU_ALU_SLL: return a << b[4:0];
      `EXU_ALU_SRL: return a >> b[4:0];
      `EXU_ALU_SRA: return xlen_t'({{32{a[31]}}, a} >> b[4:0]);
      `EXU_ALU_SLT: return {31'b0, lt};
      `EXU_ALU_SLTU: return {31'b0, ltu};
      `EXU_ALU_SLE: return {31'b0, lt | (a == b)};
      `EXU_ALU_SLEU: return {31'b0, ltu | (a == b)};
      default: return '0;
    endcase
  endfunction

  function automatic xlen_t read_csr_shadow(input csr_addr_t addr);
    case (addr)
      `EXU_CSR_MSTATUS: return sh_mstatus;
      `EXU_CSR_MTVEC: return sh_mtvec;
      `EXU_CSR_MEPC: return sh_mepc;
      `EXU_CSR_MCAUSE: return sh_mcause;
      default: return '0;
    endcase
  endfunction

  function automatic void write_csr_shadow(input csr_addr_t addr, input xlen_t val);
    case (addr)
      `EXU_CSR_MSTATUS: sh_mstatus = val;
      `EXU_CSR_MTVEC: sh_mtvec = val;
      `EXU_CSR_MEPC: sh_mepc = val;
      `EXU_CSR_MCAUSE: sh_mcause = val;
      default: ;
    endcase
  endfunction

  // expected result, advances csr and memory shadows in issue order
  function automatic exu_res_t predict(input exu_req_t r);
    exu_res_t   e;
    xlen_t      alu;
    xlen_t      old;
    xlen_t      target;
    csr_addr_t  addr;
    logic       ecall;
    logic       mret;
    logic [idx_w-1:0] idx;
    alu = alu_model(r.op1, r.op2, r.alu_op);
    ecall = r.system & r.system_func3 & (r.imm[15:4] == `EXU_SYS_ECALL);
    mret = r.system & r.system_func3 & (r.imm[15:4] == `EXU_SYS_MRET);
    addr = ecall ? `EXU_CSR_MCAUSE : (mret ? `EXU_CSR_MSTATUS : r.imm[15:4]);
    old = read_csr_shadow(addr);
    target = r.op_j + r.imm;
    idx = target[idx_w-1:0];
    e.rd = r.rd;
    e.pc = r.pc;
    e.npc = target;
    // branches, system and memory ops retire tagged
    case (r.opcode)
      `EXU_OP_B, `EXU_OP_LOAD, `EXU_OP_STORE, `EXU_OP_SYSTEM: e.retire_branch = 1'b1;
      default: e.retire_branch = 1'b0;
    endcase
    case (r.opcode)
      `EXU_OP_JAL, `EXU_OP_JALR: e.use_npc = 1'b1;
      `EXU_OP_SYSTEM: e.use_npc = ecall | mret;
      `EXU_OP_B: e.use_npc = (r.alu_op == `EXU_ALU_SUB) ? (alu == '0) : (alu != '0);
      default: e.use_npc = 1'b0;
    endcase
    if (r.rd == '0) begin
      e.reg_wdata = '0;
    end else if (r.opcode == `EXU_OP_LOAD) begin
      e.reg_wdata = sh_mem[idx];
    end else if (r.system) begin
      e.reg_wdata = old;
    end else begin
      e.reg_wdata = alu;
    end
    if (ecall) begin
      e.npc = sh_mtvec;
      sh_mepc = r.pc;
      sh_mcause = `EXU_CAUSE_ECALL;
    end else if (mret) begin
      e.npc = sh_mepc;
      // MIE takes MPIE
      write_csr_shadow(addr, {old[31:4], old[7], old[2:0]});
    end else if (r.system && r.csr_wen) begin
      case (r.imm[3:0])
        `EXU_CSRRW, `EXU_CSRRWI: write_csr_shadow(addr, r.op1);
        `EXU_CSRRS, `EXU_CSRRSI: write_csr_shadow(addr, old | r.op1);
        `EXU_CSRRC, `EXU_CSRRCI: write_csr_shadow(addr, old & ~r.op1);
        default: write_csr_shadow(addr, old);
      endcase
    end
    if (r.wen) begin
      sh_mem[idx] = r.op2;
    end
    return e;
  endfunction

  function automatic exu_req_t csr_req(input csr_addr_t addr, input logic [3:0] variant,
                                       input xlen_t val, input reg_idx_t rd);
    exu_req_t r;
    r = '0;
    r.opcode = `EXU_OP_SYSTEM;
    r.system = 1'b1;
    r.csr_wen = 1'b1;
    r.imm = {16'h0, addr, variant};
    r.op1 = val;
    r.rd = rd;
    return r;
  endfunction

  function automatic exu_req_t sys_req(input logic [11:0] fn, input reg_idx_t rd);
    exu_req_t r;
    r = '0;
    r.opcode = `EXU_OP_SYSTEM;
    r.system = 1'b1;
    r.system_func3 = 1'b1;
    r.imm = {16'h0, fn, 4'h0};
    r.rd = rd;
    return r;
  endfunction

  function automatic csr_addr_t pick_csr(input xlen_t k);
    case (k[1:0])
      2'd0: return `EXU_CSR_MSTATUS;
      2'd1: return `EXU_CSR_MTVEC;
      2'd2: return `EXU_CSR_MEPC;
      default: return `EXU_CSR_MCAUSE;
    endcase
  endfunction

  function automatic alu_op_t pick_branch_op(input int k);
    case (k % 6)
      0: return `EXU_ALU_SUB;
      1: return `EXU_ALU_XOR;
      2: return `EXU_ALU_SLT;
      3: return `EXU_ALU_SLTU;
      4: return `EXU_ALU_SLE;
      default: return `EXU_ALU_SLEU;
    endcase
  endfunction

  // called and returns 2 ns after a rising edge
  task automatic issue(input exu_req_t r);
    r.pc = pc_next;
    pc_next = pc_next + 32'd4;
    req_i = r;
    req_valid_i = 1'b1;
    @(negedge clk);
    while (!req_ready_o) @(negedge clk);
    exp_q.push_back(predict(r));
    n_issued++;
    @(posedge clk);
    #2;
    req_valid_i = 1'b0;
  endtask

  task automatic report_mismatch(input string field, input xlen_t got, input xlen_t want);
    errors++;
    $display("FAIL %0t: result %0d field %s got %h expected %h",
             $time, n_checked, field, got, want);
  endtask

  initial begin
    exu_req_t   r;
    int         k;
    logic [3:0] variant;
    rst = 1'b1;
    req_i = '0;
    req_valid_i = 1'b0;
    res_ready_i = 1'b0;
    repeat (16) @(posedge clk);
    #2;
    rst = 1'b0;

    for (int i = 0; i < n_alu; i++) begin
      r = '0;
      r.opcode = op_reg;
      r.alu_op = alu_op_t'(i % 12);
      r.op1 = rand_bits(32);
      r.op2 = (i % 4 == 0) ? r.op1 : rand_bits(32);
      r.rd = (i % 5 == 0) ? reg_idx_t'(0) : reg_idx_t'(rand_bits(4));
      r.op_j = rand_bits(32);
      issue(r);
    end

    for (int i = 0; i < n_br; i++) begin
      r = '0;
      r.opcode = `EXU_OP_B;
      r.alu_op = pick_branch_op(i);
      r.op1 = rand_bits(32);
      r.op2 = rand_bits(1) ? r.op1 : rand_bits(32);
      r.op_j = rand_bits(32);
      r.imm = rand_bits(13);
      issue(r);
    end

    for (int i = 0; i < n_jmp; i++) begin
      r = '0;
      r.opcode = (i < n_jmp / 2) ? `EXU_OP_JAL : `EXU_OP_JALR;
      r.alu_op = `EXU_ALU_ADD;
      r.op1 = rand_bits(32);
      r.op2 = 32'd4;
      r.rd = reg_idx_t'(rand_bits(4));
      r.op_j = rand_bits(32);
      r.imm = rand_bits(20);
      issue(r);
    end

    for (int i = 0; i < n_csr; i++) begin
      k = int'(rand_bits(3)) % 6;
      variant = (k < 3) ? 4'(k + 1) : 4'(k + 2);
      r = csr_req(pick_csr(rand_bits(2)), variant,
                  variant[2] ? rand_bits(5) : rand_bits(32), reg_idx_t'(rand_bits(4)));
      issue(r);
    end

    // trap entry and return
    issue(csr_req(`EXU_CSR_MTVEC, `EXU_CSRRW, 32'h0000_0400, 4'd1));
    issue(csr_req(`EXU_CSR_MSTATUS, `EXU_CSRRS, 32'h0000_0080, 4'd2));
    issue(sys_req(`EXU_SYS_ECALL, 4'd0));
    issue(csr_req(`EXU_CSR_MEPC, `EXU_CSRRS, 32'h0, 4'd5));
    issue(csr_req(`EXU_CSR_MCAUSE, `EXU_CSRRS, 32'h0, 4'd6));
    issue(sys_req(`EXU_SYS_MRET, 4'd2));
    issue(csr_req(`EXU_CSR_MSTATUS, `EXU_CSRRCI, 32'h8, 4'd4));
    issue(sys_req(`EXU_SYS_ECALL, 4'd3));

    for (int i = 0; i < n_mem; i++) begin
      addrs[i] = rand_bits(32);
      r = '0;
      r.opcode = `EXU_OP_STORE;
      r.wen = 1'b1;
      r.op2 = rand_bits(32);
      r.rd = reg_idx_t'(rand_bits(4));
      r.op_j = addrs[i];
      issue(r);
    end

    // upper address bits differ from the store
    for (int i = 0; i < n_mem; i++) begin
      r = '0;
      r.opcode = `EXU_OP_LOAD;
      r.ren = 1'b1;
      r.rd = (i % 4 == 0) ? reg_idx_t'(0) : reg_idx_t'(rand_bits(4));
      r.op_j = addrs[(i * 7) % n_mem] + (xlen_t'(i) << idx_w);
      issue(r);
    end

    wait (exp_q.size() == 0);
    repeat (4) @(posedge clk);
    if (n_checked != n_issued) begin
      errors++;
      $display("result count wrong: %0d issued but %0d checked", n_issued, n_checked);
    end
    $display("closing: %0d errors, %0d results checked", errors, n_checked);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // about one stall cycle in four
  initial begin
    logic b0;
    logic b1;
    forever begin
      @(posedge clk);
      #2;
      stall_lfsr = lfsr_next(stall_lfsr);
      b0 = stall_lfsr[0];
      stall_lfsr = lfsr_next(stall_lfsr);
      b1 = stall_lfsr[0];
      res_ready_i = !(b0 && b1);
    end
  end

  initial begin
    exu_res_t want;
    exu_res_t held_res;
    logic     held;
    held = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst && held && res_valid_o && (res_o !== held_res)) begin
        errors++;
        $display("FAIL %0t: held result changed under back-pressure", $time);
      end
      if (!rst && res_valid_o && res_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("result at %0t arrived with no instruction outstanding", $time);
        end else begin
          want = exp_q.pop_front();
          if (res_o.pc !== want.pc) report_mismatch("pc", res_o.pc, want.pc);
          if (res_o.rd !== want.rd) report_mismatch("rd", 32'(res_o.rd), 32'(want.rd));
          if (res_o.reg_wdata !== want.reg_wdata)
            report_mismatch("reg_wdata", res_o.reg_wdata, want.reg_wdata);
          if (res_o.use_npc !== want.use_npc)
            report_mismatch("use_npc", 32'(res_o.use_npc), 32'(want.use_npc));
          if (want.use_npc && (res_o.npc !== want.npc))
            report_mismatch("npc", res_o.npc, want.npc);
          if (res_o.retire_branch !== want.retire_branch)
            report_mismatch("retire_branch", 32'(res_o.retire_branch),
                            32'(want.retire_branch));
          n_checked++;
        end
      end
      held = !rst && res_valid_o && !res_ready_i;
      held_res = res_o;
    end
  end

  initial begin
    while (cycles <= timeout_cycles) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles, %0d of %0d results checked",
             cycles, n_checked, n_total);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/exu_pkg.sv
verilog/exu_alu.sv
verilog/exu_csr.sv
verilog/exu_stage.sv
verilog/exu_lsu.sv
verilog/exu_top.sv
verif/exu_tb.sv

// File: Bender.yml
package:
  name: exu

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/exu_pkg.sv
      - verilog/exu_alu.sv
      - verilog/exu_csr.sv
      - verilog/exu_stage.sv
      - verilog/exu_lsu.sv
      - verilog/exu_top.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - verif/exu_tb.sv
